//--- vlog.f
verilog/mem_wb_pkg.sv
verilog/mem_wb_if.sv
verilog/store_align.sv
verilog/load_extract.sv
verilog/mem_stage.sv
verilog/wb_stage.sv
verilog/mem_wb_top.sv
dv/clk_gen.sv
dv/tb_mem_wb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log says so
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mem_wb -f vlog.f -o sim_tb_mem_wb

./obj_dir/sim_tb_mem_wb > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
  exit 0
fi
exit 1

//--- dv/tb_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_wb;

  localparam int unsigned SEED       = 32'h65bd_3684;
  localparam int          N_OPS      = 8 + 12 + 24 + 60 + 2;
  localparam int          TIMEOUT_NS = (N_OPS * 20 + 8) * 4;

  logic                    clk;
  logic                    nrst;
  mem_wb_pkg::word_t       ex_alu_out;
  mem_wb_pkg::word_t       ex_store_data;
  mem_wb_pkg::word_t       ex_pc;
  mem_wb_pkg::reg_addr_t   ex_rd;
  mem_wb_pkg::store_size_t ex_store_size;
  logic                    ex_load;
  mem_wb_pkg::load_size_t  ex_load_size;
  logic                    ex_load_signed;
  mem_wb_pkg::wb_src_t     ex_wb_src;
  logic                    ex_halt;
  logic                    ex_ready;
  mem_wb_pkg::word_t       daddr;
  mem_wb_pkg::word_t       dstore;
  mem_wb_pkg::byte_en_t    dwen;
  logic                    dren;
  logic                    dwait = 1'b0;
  mem_wb_pkg::word_t       dload;
  logic                    reg_wen;
  mem_wb_pkg::reg_addr_t   reg_wsel;
  mem_wb_pkg::word_t       reg_wdat;
  logic                    halt;

  mem_wb_pkg::word_t       mem [16];
  mem_wb_pkg::word_t       shadow [16];
  mem_wb_pkg::reg_addr_t   exp_rd [$];
  mem_wb_pkg::word_t       exp_dat [$];
  string                   exp_name [$];
  mem_wb_pkg::reg_addr_t   chk_rd;
  mem_wb_pkg::word_t       chk_dat;
  string                   chk_name;
  logic                    stage_load;
  mem_wb_pkg::byte_en_t    stage_lanes;
  logic                    wait_en = 1'b0;
  logic                    halt_sent = 1'b0;
  int                      err_value = 0;
  int                      err_other = 0;
  int unsigned             seed_ret;

  clk_gen clk_gen_i (
    .clk  (clk),
    .nrst (nrst)
  );

  mem_wb_top mem_wb_top_i (.*);

  // Power-up contents, distinct for every word
  function automatic mem_wb_pkg::word_t fill_word(input int idx);
    return (idx + 1) * 32'h0135_79bd ^ 32'ha5c3_0f96;
  endfunction

  // Lane rule for stores, applied to the shadow copy
  function automatic mem_wb_pkg::word_t merge_store(input mem_wb_pkg::word_t old,
      input logic [1:0] lane, input mem_wb_pkg::store_size_t size,
      input mem_wb_pkg::word_t data);
    mem_wb_pkg::word_t res;
    int                nbytes;
    int                first;
    res    = old;
    nbytes = 0;
    first  = 0;
    if (size == mem_wb_pkg::ST_BYTE) begin
      nbytes = 1;
      first  = int'(lane);
    end else if (size == mem_wb_pkg::ST_HALF) begin
      nbytes = 2;
      first  = lane[1] ? 2 : 0;
    end else if (size == mem_wb_pkg::ST_WORD) begin
      nbytes = 4;
    end
    for (int i = 0; i < nbytes; i++) begin
      res[(first + i) * 8 +: 8] = data[i * 8 +: 8];
    end
    return res;
  endfunction

  // Byte enables a store of this size raises at this lane
  function automatic mem_wb_pkg::byte_en_t lane_mask(input logic [1:0] lane,
      input mem_wb_pkg::store_size_t size);
    mem_wb_pkg::byte_en_t m;
    m = 4'b0000;
    if (size == mem_wb_pkg::ST_BYTE) begin
      m[lane] = 1'b1;
    end else if (size == mem_wb_pkg::ST_HALF) begin
      m = lane[1] ? 4'b1100 : 4'b0011;
    end else if (size == mem_wb_pkg::ST_WORD) begin
      m = 4'b1111;
    end
    return m;
  endfunction

  // Reference writeback value from op fields and the addressed word
  function automatic mem_wb_pkg::word_t expected_wdat(input mem_wb_pkg::wb_src_t src,
      input mem_wb_pkg::word_t alu, input mem_wb_pkg::word_t pc,
      input mem_wb_pkg::load_size_t size, input logic sgn, input mem_wb_pkg::word_t mword);
    mem_wb_pkg::word_t val;
    logic [7:0]        b;
    logic [15:0]       h;
    b   = mword[int'(alu[1:0]) * 8 +: 8];
    h   = mword[(alu[1] ? 16 : 0) +: 16];
    val = alu;
    if (src == mem_wb_pkg::WB_LINK) begin
      val = pc + mem_wb_pkg::LINK_OFFSET;
    end else if (src == mem_wb_pkg::WB_MEM) begin
      if (size == mem_wb_pkg::LD_BYTE) begin
        val = {{24{sgn & b[7]}}, b};
      end else if (size == mem_wb_pkg::LD_HALF) begin
        val = {{16{sgn & h[15]}}, h};
      end else begin
        val = mword;
      end
    end
    return val;
  endfunction

  task automatic compare_word(input string name, input mem_wb_pkg::word_t exp,
      input mem_wb_pkg::word_t act);
    assert (exp === act) else begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      err_value++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("At %0t ns: %s", $time, what);
      err_other++;
    end
  endtask

  task automatic drive_bubble();
    ex_alu_out     <= '0;
    ex_store_data  <= '0;
    ex_pc          <= '0;
    ex_rd          <= '0;
    ex_store_size  <= mem_wb_pkg::ST_NONE;
    ex_load        <= 1'b0;
    ex_load_size   <= mem_wb_pkg::LD_WORD;
    ex_load_signed <= 1'b0;
    ex_wb_src      <= mem_wb_pkg::WB_ALU;
    ex_halt        <= 1'b0;
  endtask

  // Drives one op, records its expected write and waits until it is taken
  task automatic issue(input string name, input mem_wb_pkg::word_t alu,
      input mem_wb_pkg::word_t sdata, input mem_wb_pkg::word_t pc,
      input mem_wb_pkg::reg_addr_t rd, input mem_wb_pkg::store_size_t ssize,
      input logic ld, input mem_wb_pkg::load_size_t lsize, input logic lsgn,
      input mem_wb_pkg::wb_src_t src, input logic hlt);
    ex_alu_out     <= alu;
    ex_store_data  <= sdata;
    ex_pc          <= pc;
    ex_rd          <= rd;
    ex_store_size  <= ssize;
    ex_load        <= ld;
    ex_load_size   <= lsize;
    ex_load_signed <= lsgn;
    ex_wb_src      <= src;
    ex_halt        <= hlt;
    if (ssize != mem_wb_pkg::ST_NONE) begin
      shadow[alu[5:2]] = merge_store(shadow[alu[5:2]], alu[1:0], ssize, sdata);
    end
    if (rd != '0 && !halt_sent) begin
      exp_rd.push_back(rd);
      exp_dat.push_back(expected_wdat(src, alu, pc, lsize, lsgn, shadow[alu[5:2]]));
      exp_name.push_back(name);
    end
    @(posedge clk);
    while (!ex_ready) begin
      @(posedge clk);
    end
  endtask

  task automatic random_op();
    int                kind;
    mem_wb_pkg::word_t addr;
    kind = int'($urandom % 4);
    addr = $urandom % 64;
    case (kind)
      0: issue("random alu", $urandom, $urandom, $urandom, 5'($urandom),
               mem_wb_pkg::ST_NONE, 1'b0, mem_wb_pkg::LD_WORD, 1'b0,
               mem_wb_pkg::WB_ALU, 1'b0);
      1: issue("random link", $urandom, $urandom, $urandom, 5'($urandom),
               mem_wb_pkg::ST_NONE, 1'b0, mem_wb_pkg::LD_WORD, 1'b0,
               mem_wb_pkg::WB_LINK, 1'b0);
      2: issue("random store", addr, $urandom, $urandom, 5'd0,
               mem_wb_pkg::store_size_t'(1 + $urandom % 3), 1'b0, mem_wb_pkg::LD_WORD,
               1'b0, mem_wb_pkg::WB_ALU, 1'b0);
      default: issue("random load", addr, $urandom, $urandom, 5'($urandom),
                     mem_wb_pkg::ST_NONE, 1'b1, mem_wb_pkg::load_size_t'($urandom % 3),
                     1'($urandom), mem_wb_pkg::WB_MEM, 1'b0);
    endcase
  endtask

  // Data memory model, filled during reset
  always @(posedge clk) begin
    if (!nrst) begin
      for (int i = 0; i < 16; i++) begin
        mem[i] <= fill_word(i);
      end
    end else if (!dwait) begin
      for (int k = 0; k < 4; k++) begin
        if (dwen[k]) begin
          mem[daddr[5:2]][k * 8 +: 8] <= dstore[k * 8 +: 8];
        end
      end
    end
  end

  assign dload = (dren && !dwait) ? mem[daddr[5:2]] : 32'hdead_beef;

  // About one wait cycle in three
  always @(posedge clk) begin
    dwait <= wait_en && ($urandom % 3 == 0);
  end

  // Access of the op the memory stage holds, taken from the issued fields
  always @(posedge clk) begin
    if (!nrst) begin
      stage_load  <= 1'b0;
      stage_lanes <= 4'b0000;
    end else if (ex_ready) begin
      stage_load  <= ex_load;
      stage_lanes <= lane_mask(ex_alu_out[1:0], ex_store_size);
    end
  end

  always @(posedge clk) begin
    if (nrst && !halt_sent) begin
      compare_word("store lanes", mem_wb_pkg::word_t'(stage_lanes),
                   mem_wb_pkg::word_t'(dwen));
      compare_word("load request", mem_wb_pkg::word_t'(stage_load),
                   mem_wb_pkg::word_t'(dren));
      check_true(ex_ready == !((stage_load || (|stage_lanes)) && dwait),
                 "ex_ready does not follow the pending access and dwait");
    end
    if (nrst && reg_wen) begin
      if (exp_rd.size() == 0) begin
        check_true(1'b0, "register write without a matching issued operation");
      end else begin
        chk_rd   = exp_rd.pop_front();
        chk_dat  = exp_dat.pop_front();
        chk_name = exp_name.pop_front();
        compare_word({chk_name, " rd"}, mem_wb_pkg::word_t'(chk_rd),
                     mem_wb_pkg::word_t'(reg_wsel));
        compare_word({chk_name, " data"}, chk_dat, reg_wdat);
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Run stuck, watchdog expired after %0d ns", TIMEOUT_NS);
    err_other++;
    $display("Errors: value %0d, other %0d", err_value, err_other);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    seed_ret = $urandom(SEED);
    drive_bubble();
    for (int i = 0; i < 16; i++) begin
      shadow[i] = fill_word(i);
    end
    wait (nrst === 1'b1);
    @(posedge clk);
    check_true(!reg_wen && !dren && !halt && dwen == 4'b0000 && ex_ready,
               "outputs are not in their reset state");
    wait_en <= 1'b1;

    // ALU and link results, every third op without a destination
    for (int i = 0; i < 8; i++) begin
      issue(i[0] ? "link" : "alu", 32'h1357_0000 + i * 32'h0246_8ace, $urandom,
            32'hffff_fff0 + i * 4, (i % 3 == 0) ? 5'd0 : 5'(i + 3),
            mem_wb_pkg::ST_NONE, 1'b0, mem_wb_pkg::LD_WORD, 1'b0,
            i[0] ? mem_wb_pkg::WB_LINK : mem_wb_pkg::WB_ALU, 1'b0);
    end

    // One word per store size and alignment
    for (int sz = 1; sz < 4; sz++) begin
      for (int a = 0; a < 4; a++) begin
        issue("store", (sz - 1) * 16 + a * 5, 32'h8c71_e35a + (sz * 4 + a) * 32'h1357_9bdf,
              32'd0, 5'd0, mem_wb_pkg::store_size_t'(sz), 1'b0, mem_wb_pkg::LD_WORD,
              1'b0, mem_wb_pkg::WB_ALU, 1'b0);
      end
    end

    for (int sz = 0; sz < 3; sz++) begin
      for (int a = 0; a < 4; a++) begin
        for (int sg = 0; sg < 2; sg++) begin
          issue(sg[0] ? "load signed" : "load unsigned", ((sz * 4 + a + sg) % 12) * 4 + a,
                32'd0, 32'd0, 5'(1 + sz * 8 + a * 2 + sg), mem_wb_pkg::ST_NONE, 1'b1,
                mem_wb_pkg::load_size_t'(sz), sg[0], mem_wb_pkg::WB_MEM, 1'b0);
        end
      end
    end

    for (int n = 0; n < 60; n++) begin
      random_op();
    end

    // Halt op, then a load that must never complete
    halt_sent = 1'b1;
    issue("halt", 32'd0, 32'd0, 32'd0, 5'd0, mem_wb_pkg::ST_NONE, 1'b0,
          mem_wb_pkg::LD_WORD, 1'b0, mem_wb_pkg::WB_ALU, 1'b1);
    issue("after halt", 32'd8, 32'd0, 32'd0, 5'd9, mem_wb_pkg::ST_NONE, 1'b1,
          mem_wb_pkg::LD_WORD, 1'b0, mem_wb_pkg::WB_MEM, 1'b0);
    drive_bubble();
    while (!halt) begin
      @(posedge clk);
    end
    repeat (20) begin
      @(posedge clk);
      check_true(halt && !ex_ready && !dren && dwen == 4'b0000,
                 "halt state is not held, or the memory port is active while halted");
    end
    check_true(exp_rd.size() == 0, "writes of operations before the halt op are missing");
    for (int i = 0; i < 16; i++) begin
      compare_word("memory", shadow[i], mem[i]);
    end

    $display("Errors: value %0d, other %0d", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk,
  output logic nrst
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset held for 8 cycles, released on an edge
  initial begin
    nrst = 1'b0;
    repeat (8) @(posedge clk);
    nrst <= 1'b1;
  end

endmodule

`default_nettype wire

//--- verilog/mem_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_top (
  input  logic                     clk,
  input  logic                     nrst,
  input  mem_wb_pkg::word_t        ex_alu_out,
  input  mem_wb_pkg::word_t        ex_store_data,
  input  mem_wb_pkg::word_t        ex_pc,
  input  mem_wb_pkg::reg_addr_t    ex_rd,
  input  mem_wb_pkg::store_size_t  ex_store_size,
  input  logic                     ex_load,
  input  mem_wb_pkg::load_size_t   ex_load_size,
  input  logic                     ex_load_signed,
  input  mem_wb_pkg::wb_src_t      ex_wb_src,
  input  logic                     ex_halt,
  output logic                     ex_ready,
  output mem_wb_pkg::word_t        daddr,
  output mem_wb_pkg::word_t        dstore,
  output mem_wb_pkg::byte_en_t     dwen,
  output logic                     dren,
  input  logic                     dwait,
  input  mem_wb_pkg::word_t        dload,
  output logic                     reg_wen,
  output mem_wb_pkg::reg_addr_t    reg_wsel,
  output mem_wb_pkg::word_t        reg_wdat,
  output logic                     halt
);

  mem_wb_if m2w ();

  mem_stage mem_stage_i (
    .clk            (clk),
    .nrst           (nrst),
    .ex_alu_out     (ex_alu_out),
    .ex_store_data  (ex_store_data),
    .ex_pc          (ex_pc),
    .ex_rd          (ex_rd),
    .ex_store_size  (ex_store_size),
    .ex_load        (ex_load),
    .ex_load_size   (ex_load_size),
    .ex_load_signed (ex_load_signed),
    .ex_wb_src      (ex_wb_src),
    .ex_halt        (ex_halt),
    .dwait          (dwait),
    .ex_ready       (ex_ready),
    .daddr          (daddr),
    .dstore         (dstore),
    .dwen           (dwen),
    .dren           (dren),
    .m2w            (m2w.src)
  );

  wb_stage wb_stage_i (
    .clk      (clk),
    .nrst     (nrst),
    .dload    (dload),
    .reg_wen  (reg_wen),
    .reg_wsel (reg_wsel),
    .reg_wdat (reg_wdat),
    .halt     (halt),
    .m2w      (m2w.dst)
  );

endmodule

`default_nettype wire

//--- verilog/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
  input  logic                   clk,
  input  logic                   nrst,
  input  mem_wb_pkg::word_t      dload,
  output logic                   reg_wen,
  output mem_wb_pkg::reg_addr_t  reg_wsel,
  output mem_wb_pkg::word_t      reg_wdat,
  output logic                   halt,
  mem_wb_if.dst                  m2w
);

  mem_wb_pkg::reg_addr_t  wb_rd;
  logic                   wb_halt;
  mem_wb_pkg::wb_src_t    wb_src;
  mem_wb_pkg::load_size_t wb_ld_size;
  logic                   wb_ld_signed;
  mem_wb_pkg::word_t      wb_alu_out;
  mem_wb_pkg::word_t      wb_pc;
  mem_wb_pkg::word_t      wb_dload;
  mem_wb_pkg::word_t      ld_value;

  // A stalled memory stage sends a bubble down
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      wb_rd   <= '0;
      wb_halt <= 1'b0;
    end else if (m2w.advance) begin
      wb_rd   <= m2w.rd;
      wb_halt <= m2w.halt;
    end else begin
      wb_rd   <= '0;
      wb_halt <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (m2w.advance) begin
      wb_src       <= m2w.wb_src;
      wb_ld_size   <= m2w.load_size;
      wb_ld_signed <= m2w.load_signed;
      wb_alu_out   <= m2w.alu_out;
      wb_pc        <= m2w.pc;
      wb_dload     <= dload;
    end
  end

  // Sticky until reset
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      halt <= 1'b0;
    end else begin
      halt <= halt | wb_halt;
    end
  end

  // Memory stage freezes as soon as the halt op is here
  assign m2w.halted = halt | wb_halt;

  load_extract load_extract_i (
    .dload       (wb_dload),
    .addr_low    (wb_alu_out[1:0]),
    .load_size   (wb_ld_size),
    .load_signed (wb_ld_signed),
    .value       (ld_value)
  );

  always_comb begin
    case (wb_src)
      mem_wb_pkg::WB_MEM:  reg_wdat = ld_value;
      mem_wb_pkg::WB_LINK: reg_wdat = wb_pc + mem_wb_pkg::LINK_OFFSET;
      default:             reg_wdat = wb_alu_out;
    endcase
  end

  assign reg_wsel = wb_rd;
  assign reg_wen  = (wb_rd != '0);

  // Nothing is written to x0 or after the halt flag is up
  assert property (@(posedge clk) disable iff (!nrst)
    reg_wen |-> (reg_wsel != '0 && !halt));

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  logic                     clk,
  input  logic                     nrst,
  input  mem_wb_pkg::word_t        ex_alu_out,
  input  mem_wb_pkg::word_t        ex_store_data,
  input  mem_wb_pkg::word_t        ex_pc,
  input  mem_wb_pkg::reg_addr_t    ex_rd,
  input  mem_wb_pkg::store_size_t  ex_store_size,
  input  logic                     ex_load,
  input  mem_wb_pkg::load_size_t   ex_load_size,
  input  logic                     ex_load_signed,
  input  mem_wb_pkg::wb_src_t      ex_wb_src,
  input  logic                     ex_halt,
  input  logic                     dwait,
  output logic                     ex_ready,
  output mem_wb_pkg::word_t        daddr,
  output mem_wb_pkg::word_t        dstore,
  output mem_wb_pkg::byte_en_t     dwen,
  output logic                     dren,
  mem_wb_if.src                    m2w
);

  mem_wb_pkg::store_size_t st_size_q;
  mem_wb_pkg::word_t       st_data_q;
  logic                    load_q;
  mem_wb_pkg::byte_en_t    st_dwen;
  logic                    pending;

  // Control fields reset to a bubble
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      m2w.rd    <= '0;
      m2w.halt  <= 1'b0;
      st_size_q <= mem_wb_pkg::ST_NONE;
      load_q    <= 1'b0;
    end else if (ex_ready) begin
      m2w.rd    <= ex_rd;
      m2w.halt  <= ex_halt;
      st_size_q <= ex_store_size;
      load_q    <= ex_load;
    end
  end

  // Payload only matters once rd or an access qualifies it
  always_ff @(posedge clk) begin
    if (ex_ready) begin
      m2w.alu_out     <= ex_alu_out;
      m2w.pc          <= ex_pc;
      m2w.wb_src      <= ex_wb_src;
      m2w.load_size   <= ex_load_size;
      m2w.load_signed <= ex_load_signed;
      st_data_q       <= ex_store_data;
    end
  end

  store_align store_align_i (
    .addr_low   (m2w.alu_out[1:0]),
    .store_size (st_size_q),
    .store_data (st_data_q),
    .dwen       (st_dwen),
    .dstore     (dstore)
  );

  // Address comes straight from the ALU result
  assign daddr = m2w.alu_out;

  // No new access once halt has reached writeback
  assign dren = load_q & ~m2w.halted;
  assign dwen = m2w.halted ? 4'b0000 : st_dwen;

  assign pending     = dren | (|dwen);
  assign m2w.advance = ~m2w.halted & ~(pending & dwait);
  assign ex_ready    = m2w.advance;

  // Only the lane masks store_align can produce
  assert property (@(posedge clk) disable iff (!nrst)
    dwen inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                 4'b0011, 4'b1100, 4'b1111});

  // Halt stays set and the memory port stays quiet after it
  assert property (@(posedge clk) disable iff (!nrst)
    m2w.halted |=> (m2w.halted && !dren && dwen == 4'b0000));

endmodule

`default_nettype wire

//--- verilog/load_extract.sv
`timescale 1ns/1ps
`default_nettype none

module load_extract (
  input  mem_wb_pkg::word_t       dload,
  input  logic [1:0]              addr_low,
  input  mem_wb_pkg::load_size_t  load_size,
  input  logic                    load_signed,
  output mem_wb_pkg::word_t       value
);

  mem_wb_pkg::word_t shifted;
  logic [7:0]        ld_byte;
  logic [15:0]       ld_half;
  logic              byte_ext;
  logic              half_ext;

  // Bring the addressed byte down to lane 0
  assign shifted = dload >> {addr_low, 3'b000};
  assign ld_byte = shifted[7:0];

  // Upper or lower half by address bit 1
  assign ld_half = addr_low[1] ? dload[31:16] : dload[15:0];

  // Fill bit is zero for unsigned loads
  assign byte_ext = load_signed & ld_byte[7];
  assign half_ext = load_signed & ld_half[15];

  always_comb begin
    case (load_size)
      mem_wb_pkg::LD_BYTE: begin
        value = {{24{byte_ext}}, ld_byte};
      end
      mem_wb_pkg::LD_HALF: begin
        value = {{16{half_ext}}, ld_half};
      end
      default: begin
        value = dload;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align (
  input  logic [1:0]               addr_low,
  input  mem_wb_pkg::store_size_t  store_size,
  input  mem_wb_pkg::word_t        store_data,
  output mem_wb_pkg::byte_en_t     dwen,
  output mem_wb_pkg::word_t        dstore
);

  logic [7:0]  st_byte;
  logic [15:0] st_half;

  assign st_byte = store_data[7:0];
  assign st_half = store_data[15:0];

  always_comb begin
    case (store_size)
      mem_wb_pkg::ST_BYTE: begin
        // Byte moves to the lane picked by the low address bits
        dwen   = 4'b0001 << addr_low;
        dstore = {24'd0, st_byte} << {addr_low, 3'b000};
      end
      mem_wb_pkg::ST_HALF: begin
        // Bit 0 is ignored for halfwords
        if (addr_low[1]) begin
          dwen   = 4'b1100;
          dstore = {st_half, 16'd0};
        end else begin
          dwen   = 4'b0011;
          dstore = {16'd0, st_half};
        end
      end
      mem_wb_pkg::ST_WORD: begin
        dwen   = 4'b1111;
        dstore = store_data;
      end
      default: begin
        // No store this op
        dwen   = 4'b0000;
        dstore = store_data;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/mem_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_wb_if;

  // Memory-stage op completes this cycle
  logic                     advance;

  // Registered op fields from the memory stage
  mem_wb_pkg::reg_addr_t    rd;
  mem_wb_pkg::wb_src_t      wb_src;
  mem_wb_pkg::load_size_t   load_size;
  logic                     load_signed;
  mem_wb_pkg::word_t        alu_out;
  mem_wb_pkg::word_t        pc;
  logic                     halt;

  // Halt seen in writeback or already latched
  logic                     halted;

  modport src (
    output advance, rd, wb_src, load_size, load_signed, alu_out, pc, halt,
    input  halted
  );

  modport dst (
    input  advance, rd, wb_src, load_size, load_signed, alu_out, pc, halt,
    output halted
  );

endinterface

`default_nettype wire

//--- verilog/mem_wb_pkg.sv
`default_nettype none

package mem_wb_pkg;

  // Data word and byte address
  typedef logic [31:0] word_t;

  // Destination register, zero means no write
  typedef logic [4:0] reg_addr_t;

  // One enable per byte lane
  typedef logic [3:0] byte_en_t;

  typedef logic [1:0] store_size_t;
  typedef logic [1:0] load_size_t;

  // Writeback source select
  typedef logic [1:0] wb_src_t;

  // Store widths
  localparam store_size_t ST_NONE = 2'd0;
  localparam store_size_t ST_BYTE = 2'd1;
  localparam store_size_t ST_HALF = 2'd2;
  localparam store_size_t ST_WORD = 2'd3;

  // Load widths
  localparam load_size_t LD_BYTE = 2'd0;
  localparam load_size_t LD_HALF = 2'd1;
  localparam load_size_t LD_WORD = 2'd2;

  // Writeback sources
  localparam wb_src_t WB_ALU  = 2'd0;
  localparam wb_src_t WB_MEM  = 2'd1;
  localparam wb_src_t WB_LINK = 2'd2;

  // Return address is pc plus one instruction
  localparam word_t LINK_OFFSET = 32'd4;

endpackage

`default_nettype wire
